/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_pkg.sv
      - hdl/stage_reg.sv
      - hdl/instr_fetch.sv
      - hdl/instr_decode.sv
      - hdl/hazard_forward.sv
      - hdl/execute.sv
      - hdl/memory_access.sv
      - hdl/mips_pipeline.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/mips_pipeline_assert.sv
      - bench/mips_pipeline_tb.sv

/* bench/mips_pipeline_assert.sv */
`include "mips_defs.svh"

module mips_pipeline_assert (
   input logic                   i_clock,
   input logic                   reset,
   input logic                   i_halt,
   input logic [`MIPS_RADDR-1:0] i_dbg_reg_addr,
   input logic [`MIPS_XLEN-1:0]  i_dbg_reg_data
);
   timeunit 1ns;
   timeprecision 100ps;

   int failures = 0;

   halt_low_after_reset: assert property (@(posedge i_clock) reset |=> !i_halt)
   else begin
      $error("o_halt is high in the cycle after reset");
      failures++;
   end

   // Sticky until the next reset
   halt_sticky: assert property (@(posedge i_clock) i_halt && !reset |=> i_halt)
   else begin
      $error("o_halt fell without a reset");
      failures++;
   end

   r0_reads_zero: assert property (@(posedge i_clock)
      i_dbg_reg_addr == '0 |-> i_dbg_reg_data == '0)
   else begin
      $error("register 0 read back nonzero");
      failures++;
   end

endmodule

bind mips_pipeline mips_pipeline_assert u_assert (
   .i_clock        (i_clock),
   .reset          (reset),
   .i_halt         (o_halt),
   .i_dbg_reg_addr (i_dbg_reg_addr),
   .i_dbg_reg_data (o_dbg_reg_data)
);

/* bench/mips_pipeline_tb.sv */
`include "mips_defs.svh"

module mips_pipeline_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CYCLES_PER_TEST = 40;
   localparam logic [`MIPS_XLEN-1:0] HALT_WORD = {`MIPS_OP_HALT, 26'd0};

   typedef struct {
      string                  name;
      int                     first;
      int                     len;
      logic [`MIPS_RADDR-1:0] reg_addr;
      logic [`MIPS_XLEN-1:0]  expected;
   } test_t;

   logic                     i_clock;
   logic                     reset;
   logic                     i_imem_we;
   logic [`MIPS_IMEM_AW-1:0] i_imem_addr;
   logic [`MIPS_XLEN-1:0]    i_imem_data;
   logic                     i_start;
   logic [`MIPS_RADDR-1:0]   i_dbg_reg_addr;
   logic                     o_halt;
   logic [`MIPS_XLEN-1:0]    o_dbg_reg_data;

   // All programs back to back with each test pointing at its slice
   logic [`MIPS_XLEN-1:0] words [$];
   test_t                 tests [$];
   int                    pending_first = 0;
   int                    errors = 0;
   int                    checks = 0;
   int                    cycles = 0;
   int                    limit = 0;

   mips_pipeline dut (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_imem_we      (i_imem_we),
      .i_imem_addr    (i_imem_addr),
      .i_imem_data    (i_imem_data),
      .i_start        (i_start),
      .i_dbg_reg_addr (i_dbg_reg_addr),
      .o_halt         (o_halt),
      .o_dbg_reg_data (o_dbg_reg_data)
   );

   initial begin
      i_clock = 1'b0;
      forever #5 i_clock = ~i_clock;
   end

   function automatic logic [`MIPS_XLEN-1:0] itype(input logic [5:0] op, input int rt,
                                                  input int rs, input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [`MIPS_XLEN-1:0] rtype(input logic [5:0] fn, input int rd,
                                                  input int rs, input int rt);
      return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
   endfunction

   task automatic emit(input logic [`MIPS_XLEN-1:0] word);
      words.push_back(word);
   endtask

   // r1 = a, r2 = b
   task automatic constants(input int a, input int b);
      emit(itype(`MIPS_OP_ADDIU, 1, 0, a));
      emit(itype(`MIPS_OP_ADDIU, 2, 0, b));
   endtask

   task automatic add_test(input string name, input int rd, input logic [`MIPS_XLEN-1:0] value);
      test_t t;
      t.name     = name;
      t.first    = pending_first;
      t.len      = words.size() - pending_first;
      t.reg_addr = rd[`MIPS_RADDR-1:0];
      t.expected = value;
      tests.push_back(t);
      pending_first = words.size();
   endtask

   task automatic build_table();
      constants(12, 10);
      emit(rtype(`MIPS_FN_ADDU, 3, 1, 2));
      add_test("addu", 3, 32'd22);
      constants(12, 10);
      emit(rtype(`MIPS_FN_SUBU, 3, 2, 1));
      add_test("subu", 3, 32'hffff_fffe);
      constants(12, 10);
      emit(rtype(`MIPS_FN_AND, 3, 1, 2));
      add_test("and", 3, 32'd8);
      constants(12, 10);
      emit(rtype(`MIPS_FN_OR, 3, 1, 2));
      add_test("or", 3, 32'd14);
      // Signed compare of -5 against 3
      constants(-5, 3);
      emit(rtype(`MIPS_FN_SLT, 3, 1, 2));
      add_test("slt_neg_pos", 3, 32'd1);
      constants(-5, 3);
      emit(itype(`MIPS_OP_ADDIU, 3, 0, 9));
      emit(rtype(`MIPS_FN_SLT, 3, 2, 1));
      add_test("slt_pos_neg", 3, 32'd0);
      // Sources at distance 1 and 2
      emit(itype(`MIPS_OP_ADDIU, 1, 0, 1));
      emit(itype(`MIPS_OP_ADDIU, 2, 1, 2));
      emit(rtype(`MIPS_FN_ADDU, 3, 2, 1));
      emit(rtype(`MIPS_FN_ADDU, 4, 3, 2));
      emit(itype(`MIPS_OP_ADDIU, 4, 4, 100));
      add_test("fwd_chain", 4, 32'd107);
      constants(85, 8);
      emit(itype(`MIPS_OP_SW, 1, 2, 4));
      emit(itype(`MIPS_OP_LW, 3, 2, 4));
      add_test("store_load", 3, 32'd85);
      constants(32'h1234, 16);
      emit(itype(`MIPS_OP_SW, 1, 2, 0));
      emit(itype(`MIPS_OP_LW, 3, 2, 0));
      emit(rtype(`MIPS_FN_ADDU, 4, 3, 1));
      add_test("load_use_rs", 4, 32'h0000_2468);
      constants(32'h0321, 20);
      emit(itype(`MIPS_OP_SW, 1, 2, 8));
      emit(itype(`MIPS_OP_LW, 3, 2, 8));
      emit(rtype(`MIPS_FN_ADDU, 4, 1, 3));
      add_test("load_use_rt", 4, 32'h0000_0642);
      // r0 sourced two slots after the write to it
      emit(itype(`MIPS_OP_ADDIU, 0, 0, 77));
      emit(itype(`MIPS_OP_ADDIU, 2, 0, 1));
      emit(itype(`MIPS_OP_ADDIU, 1, 0, 5));
      add_test("r0_write", 1, 32'd5);
      emit(itype(`MIPS_OP_ADDIU, 0, 0, 77));
      emit(rtype(`MIPS_FN_ADDU, 1, 0, 0));
      emit(itype(`MIPS_OP_ADDIU, 1, 1, 5));
      add_test("r0_source", 1, 32'd5);
      emit(itype(`MIPS_OP_ADDIU, 1, 0, 5));
      emit(HALT_WORD);
      emit(itype(`MIPS_OP_ADDIU, 2, 0, 9));
      add_test("after_halt", 2, 32'd0);
      // r1 was left at 5 by the run before
      emit(itype(`MIPS_OP_ADDIU, 3, 1, 6));
      add_test("fresh_regs", 3, 32'd6);
   endtask

   task automatic apply_reset();
      @(posedge i_clock);
      reset <= 1'b1;
      repeat (3) @(posedge i_clock);
      reset <= 1'b0;
   endtask

   // Program words followed by HALT
   task automatic load_program(input int first, input int len);
      for (int k = 0; k <= len; k++) begin
         @(posedge i_clock);
         i_imem_we   <= 1'b1;
         i_imem_addr <= k[`MIPS_IMEM_AW-1:0];
         i_imem_data <= (k < len) ? words[first + k] : HALT_WORD;
      end
      @(posedge i_clock);
      i_imem_we <= 1'b0;
   endtask

   task automatic start_run();
      @(posedge i_clock);
      i_start <= 1'b1;
      @(posedge i_clock);
      i_start <= 1'b0;
   endtask

   task automatic wait_halt();
      do begin
         @(negedge i_clock);
      end while (o_halt !== 1'b1);
   endtask

   task automatic check_value(input string name, input logic [`MIPS_XLEN-1:0] expected,
                              input logic [`MIPS_XLEN-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   always @(posedge i_clock) begin
      cycles <= cycles + 1;
   end

   initial begin
      wait (limit != 0 && cycles >= limit);
      $display("Timeout: o_halt did not come within %0d clock cycles", limit);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      reset          = 1'b1;
      i_imem_we      = 1'b0;
      i_imem_addr    = '0;
      i_imem_data    = '0;
      i_start        = 1'b0;
      i_dbg_reg_addr = '0;
      build_table();
      limit = tests.size() * CYCLES_PER_TEST;
      foreach (tests[i]) begin
         apply_reset();
         load_program(tests[i].first, tests[i].len);
         start_run();
         wait_halt();
         @(posedge i_clock);
         i_dbg_reg_addr <= tests[i].reg_addr;
         @(negedge i_clock);
         check_value(tests[i].name, tests[i].expected, o_dbg_reg_data);
      end
      errors += dut.u_assert.failures;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, dut.u_assert.failures);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* hdl/execute.sv */
`include "mips_defs.svh"

module execute (
   input  mips_pkg::id_ex_t   i_id_ex,
   input  mips_pkg::ex_mem_t  i_ex_mem,
   input  mips_pkg::mem_wb_t  i_mem_wb,
   input  mips_pkg::fwd_sel_t i_fwd_a,
   input  mips_pkg::fwd_sel_t i_fwd_b,
   output mips_pkg::ex_mem_t  o_ex_mem
);

   logic [`MIPS_XLEN-1:0] op_a;
   logic [`MIPS_XLEN-1:0] rt_fwd;
   logic [`MIPS_XLEN-1:0] op_b;
   logic [`MIPS_XLEN-1:0] result;

   always_comb begin
      case (i_fwd_a)
         mips_pkg::FWD_MEM: op_a = i_ex_mem.alu_result;
         mips_pkg::FWD_WB:  op_a = i_mem_wb.wb_data;
         default:           op_a = i_id_ex.rs_val;
      endcase
      case (i_fwd_b)
         mips_pkg::FWD_MEM: rt_fwd = i_ex_mem.alu_result;
         mips_pkg::FWD_WB:  rt_fwd = i_mem_wb.wb_data;
         default:           rt_fwd = i_id_ex.rt_val;
      endcase
      op_b = i_id_ex.imm_sel ? i_id_ex.imm : rt_fwd;
   end

   always_comb begin
      case (i_id_ex.alu_op)
         mips_pkg::ALU_SUB: result = op_a - op_b;
         mips_pkg::ALU_AND: result = op_a & op_b;
         mips_pkg::ALU_OR:  result = op_a | op_b;
         mips_pkg::ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default:           result = op_a + op_b;
      endcase
   end

   always_comb begin
      o_ex_mem.valid      = i_id_ex.valid;
      o_ex_mem.alu_result = result;
      o_ex_mem.store_data = rt_fwd;
      o_ex_mem.load       = i_id_ex.load;
      o_ex_mem.store      = i_id_ex.store;
      o_ex_mem.reg_write  = i_id_ex.reg_write;
      o_ex_mem.halt       = i_id_ex.halt;
      o_ex_mem.rd         = i_id_ex.rd;
   end

endmodule

/* hdl/hazard_forward.sv */
`include "mips_defs.svh"

module hazard_forward (
   input  logic [`MIPS_RADDR-1:0] i_rs,
   input  logic [`MIPS_RADDR-1:0] i_rt,
   input  logic                   i_uses_rt,
   input  mips_pkg::id_ex_t       i_id_ex,
   input  mips_pkg::ex_mem_t      i_ex_mem,
   input  mips_pkg::mem_wb_t      i_mem_wb,
   output logic                   o_stall,
   output mips_pkg::fwd_sel_t     o_fwd_a,
   output mips_pkg::fwd_sel_t     o_fwd_b
);

   logic load_rd_live;

   // Newest producer first; a load in the memory stage was already stalled for
   function automatic mips_pkg::fwd_sel_t pick(
      input logic [`MIPS_RADDR-1:0] src,
      input mips_pkg::ex_mem_t      em,
      input mips_pkg::mem_wb_t      mw
   );
      if (src == '0) begin
         return mips_pkg::FWD_RF;
      end else if (em.valid && em.reg_write && !em.load && em.rd == src) begin
         return mips_pkg::FWD_MEM;
      end else if (mw.valid && mw.reg_write && mw.rd == src) begin
         return mips_pkg::FWD_WB;
      end
      return mips_pkg::FWD_RF;
   endfunction

   assign load_rd_live = i_id_ex.valid && i_id_ex.load && i_id_ex.rd != '0;

   // Load-use needs one bubble before the value reaches writeback
   always_comb begin
      o_stall = load_rd_live &&
                (i_id_ex.rd == i_rs || (i_uses_rt && i_id_ex.rd == i_rt));
   end

   always_comb begin
      o_fwd_a = pick(i_id_ex.rs, i_ex_mem, i_mem_wb);
      o_fwd_b = pick(i_id_ex.rt, i_ex_mem, i_mem_wb);
   end

endmodule

/* hdl/instr_decode.sv */
`include "mips_defs.svh"

module instr_decode (
   input  logic                   i_clock,
   input  logic                   reset,
   input  logic [`MIPS_XLEN-1:0]  i_instr,
   input  logic                   i_instr_valid,
   input  logic                   i_wb_we,
   input  logic [`MIPS_RADDR-1:0] i_wb_rd,
   input  logic [`MIPS_XLEN-1:0]  i_wb_data,
   input  logic [`MIPS_RADDR-1:0] i_dbg_reg_addr,
   output mips_pkg::id_ex_t       o_id_ex,
   output logic [`MIPS_RADDR-1:0] o_rs,
   output logic [`MIPS_RADDR-1:0] o_rt,
   output logic                   o_uses_rt,
   output logic                   o_halt_seen,
   output logic [`MIPS_XLEN-1:0]  o_dbg_reg_data
);

   logic [`MIPS_XLEN-1:0]  regs [2**`MIPS_RADDR];
   logic [5:0]             opcode;
   logic [5:0]             funct;
   logic [`MIPS_RADDR-1:0] rs;
   logic [`MIPS_RADDR-1:0] rt;
   logic [`MIPS_RADDR-1:0] rd;
   logic [`MIPS_XLEN-1:0]  rs_val;
   logic [`MIPS_XLEN-1:0]  rt_val;
   logic                   is_rtype;
   logic                   is_addiu;
   logic                   is_lw;
   logic                   is_sw;
   logic                   is_halt;
   logic                   known_fn;
   mips_pkg::alu_op_t      fn_op;

   assign opcode = i_instr[31:26];
   assign rs     = i_instr[25:21];
   assign rt     = i_instr[20:16];
   assign rd     = i_instr[15:11];
   assign funct  = i_instr[5:0];

   assign is_rtype = i_instr_valid && opcode == `MIPS_OP_RTYPE;
   assign is_addiu = i_instr_valid && opcode == `MIPS_OP_ADDIU;
   assign is_lw    = i_instr_valid && opcode == `MIPS_OP_LW;
   assign is_sw    = i_instr_valid && opcode == `MIPS_OP_SW;
   assign is_halt  = i_instr_valid && opcode == `MIPS_OP_HALT;

   // r0 reads zero and a same-cycle writeback is passed through
   function automatic logic [`MIPS_XLEN-1:0] read_reg(input logic [`MIPS_RADDR-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (i_wb_we && i_wb_rd == addr) begin
         return i_wb_data;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rs_val         = read_reg(rs);
      rt_val         = read_reg(rt);
      o_dbg_reg_data = read_reg(i_dbg_reg_addr);
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         for (int i = 0; i < 2**`MIPS_RADDR; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb_we && i_wb_rd != '0) begin
         regs[i_wb_rd] <= i_wb_data;
      end
   end

   always_comb begin
      known_fn = 1'b1;
      case (funct)
         `MIPS_FN_ADDU: fn_op = mips_pkg::ALU_ADD;
         `MIPS_FN_SUBU: fn_op = mips_pkg::ALU_SUB;
         `MIPS_FN_AND:  fn_op = mips_pkg::ALU_AND;
         `MIPS_FN_OR:   fn_op = mips_pkg::ALU_OR;
         `MIPS_FN_SLT:  fn_op = mips_pkg::ALU_SLT;
         default: begin
            fn_op    = mips_pkg::ALU_ADD;
            known_fn = 1'b0;
         end
      endcase
   end

   always_comb begin
      o_id_ex           = '0;
      o_id_ex.valid     = i_instr_valid;
      o_id_ex.rs        = rs;
      o_id_ex.rt        = rt;
      o_id_ex.rs_val    = rs_val;
      o_id_ex.rt_val    = rt_val;
      o_id_ex.imm       = {{(`MIPS_XLEN-16){i_instr[15]}}, i_instr[15:0]};
      o_id_ex.imm_sel   = is_addiu || is_lw || is_sw;
      o_id_ex.load      = is_lw;
      o_id_ex.store     = is_sw;
      o_id_ex.reg_write = (is_rtype && known_fn) || is_addiu || is_lw;
      o_id_ex.halt      = is_halt;
      o_id_ex.rd        = is_rtype ? rd : rt;
      o_id_ex.alu_op    = is_rtype ? fn_op : mips_pkg::ALU_ADD;
   end

   // Sources for the hazard unit are zero when unused
   assign o_rs        = (is_rtype || is_addiu || is_lw || is_sw) ? rs : '0;
   assign o_rt        = rt;
   assign o_uses_rt   = is_rtype || is_sw;
   assign o_halt_seen = is_halt;

endmodule

/* hdl/instr_fetch.sv */
`include "mips_defs.svh"

module instr_fetch (
   input  logic                     i_clock,
   input  logic                     reset,
   input  logic                     i_imem_we,
   input  logic [`MIPS_IMEM_AW-1:0] i_imem_addr,
   input  logic [`MIPS_XLEN-1:0]    i_imem_data,
   input  logic                     i_start,
   input  logic                     i_stall,
   input  logic                     i_halt_seen,
   output logic [`MIPS_XLEN-1:0]    o_instr,
   output logic                     o_instr_valid
);

   logic [`MIPS_XLEN-1:0]    imem [2**`MIPS_IMEM_AW];
   logic [`MIPS_IMEM_AW-1:0] pc;
   logic                     running;

   // Host load port
   always_ff @(posedge i_clock) begin
      if (i_imem_we) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         running <= 1'b0;
      end else if (i_start) begin
         running <= 1'b1;
      end else if (i_halt_seen) begin
         running <= 1'b0;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         pc            <= '0;
         o_instr_valid <= 1'b0;
      end else if (i_start) begin
         pc            <= '0;
         o_instr_valid <= 1'b0;
      end else if (!i_stall) begin
         // Word behind HALT is fetched but dropped here
         o_instr_valid <= running && !i_halt_seen;
         if (running && !i_halt_seen) begin
            pc <= pc + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clock) begin
      if (!i_stall) begin
         o_instr <= imem[pc];
      end
   end

endmodule

/* hdl/memory_access.sv */
`include "mips_defs.svh"

module memory_access (
   input  logic              i_clock,
   input  mips_pkg::ex_mem_t i_ex_mem,
   output mips_pkg::mem_wb_t o_mem_wb
);

   logic [`MIPS_XLEN-1:0]    dmem [2**`MIPS_DMEM_AW];
   logic [`MIPS_DMEM_AW-1:0] word_addr;

   // Byte address with the low two bits ignored
   assign word_addr = i_ex_mem.alu_result[`MIPS_DMEM_AW+1:2];

   always_ff @(posedge i_clock) begin
      if (i_ex_mem.valid && i_ex_mem.store) begin
         dmem[word_addr] <= i_ex_mem.store_data;
      end
   end

   // Load data is captured by the writeback register at the next edge
   always_comb begin
      o_mem_wb.valid     = i_ex_mem.valid;
      o_mem_wb.wb_data   = i_ex_mem.load ? dmem[word_addr] : i_ex_mem.alu_result;
      o_mem_wb.reg_write = i_ex_mem.reg_write;
      o_mem_wb.halt      = i_ex_mem.halt;
      o_mem_wb.rd        = i_ex_mem.rd;
   end

endmodule

/* hdl/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath and register file
`define MIPS_XLEN     32
`define MIPS_RADDR    5

// Word address widths of the two memories
`define MIPS_IMEM_AW  6
`define MIPS_DMEM_AW  6

// Opcodes
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_LW    6'h23
`define MIPS_OP_SW    6'h2b
`define MIPS_OP_HALT  6'h3f

// R-type function codes
`define MIPS_FN_ADDU  6'h21
`define MIPS_FN_SUBU  6'h23
`define MIPS_FN_AND   6'h24
`define MIPS_FN_OR    6'h25
`define MIPS_FN_SLT   6'h2a

`endif

/* hdl/mips_pipeline.sv */
`include "mips_defs.svh"

module mips_pipeline (
   input  logic                     i_clock,
   input  logic                     reset,
   input  logic                     i_imem_we,
   input  logic [`MIPS_IMEM_AW-1:0] i_imem_addr,
   input  logic [`MIPS_XLEN-1:0]    i_imem_data,
   input  logic                     i_start,
   input  logic [`MIPS_RADDR-1:0]   i_dbg_reg_addr,
   output logic                     o_halt,
   output logic [`MIPS_XLEN-1:0]    o_dbg_reg_data
);

   logic [`MIPS_XLEN-1:0]  instr;
   logic                   instr_valid;
   logic [`MIPS_RADDR-1:0] dec_rs;
   logic [`MIPS_RADDR-1:0] dec_rt;
   logic                   dec_uses_rt;
   logic                   halt_seen;
   logic                   stall;
   mips_pkg::fwd_sel_t     fwd_a;
   mips_pkg::fwd_sel_t     fwd_b;
   mips_pkg::id_ex_t       id_ex_d;
   mips_pkg::id_ex_t       id_ex_q;
   mips_pkg::ex_mem_t      ex_mem_d;
   mips_pkg::ex_mem_t      ex_mem_q;
   mips_pkg::mem_wb_t      mem_wb_d;
   mips_pkg::mem_wb_t      mem_wb_q;

   instr_fetch u_fetch (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_imem_we     (i_imem_we),
      .i_imem_addr   (i_imem_addr),
      .i_imem_data   (i_imem_data),
      .i_start       (i_start),
      .i_stall       (stall),
      .i_halt_seen   (halt_seen),
      .o_instr       (instr),
      .o_instr_valid (instr_valid)
   );

   instr_decode u_decode (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_instr        (instr),
      .i_instr_valid  (instr_valid),
      .i_wb_we        (mem_wb_q.reg_write),
      .i_wb_rd        (mem_wb_q.rd),
      .i_wb_data      (mem_wb_q.wb_data),
      .i_dbg_reg_addr (i_dbg_reg_addr),
      .o_id_ex        (id_ex_d),
      .o_rs           (dec_rs),
      .o_rt           (dec_rt),
      .o_uses_rt      (dec_uses_rt),
      .o_halt_seen    (halt_seen),
      .o_dbg_reg_data (o_dbg_reg_data)
   );

   hazard_forward u_hazard (
      .i_rs      (dec_rs),
      .i_rt      (dec_rt),
      .i_uses_rt (dec_uses_rt),
      .i_id_ex   (id_ex_q),
      .i_ex_mem  (ex_mem_q),
      .i_mem_wb  (mem_wb_q),
      .o_stall   (stall),
      .o_fwd_a   (fwd_a),
      .o_fwd_b   (fwd_b)
   );

   // A stall turns the decode slot into a bubble
   stage_reg #(.T(mips_pkg::id_ex_t)) u_id_ex_reg (
      .i_clock  (i_clock),
      .reset    (reset),
      .i_hold   (1'b0),
      .i_bubble (stall),
      .i_d      (id_ex_d),
      .o_q      (id_ex_q)
   );

   execute u_execute (
      .i_id_ex  (id_ex_q),
      .i_ex_mem (ex_mem_q),
      .i_mem_wb (mem_wb_q),
      .i_fwd_a  (fwd_a),
      .i_fwd_b  (fwd_b),
      .o_ex_mem (ex_mem_d)
   );

   stage_reg #(.T(mips_pkg::ex_mem_t)) u_ex_mem_reg (
      .i_clock  (i_clock),
      .reset    (reset),
      .i_hold   (1'b0),
      .i_bubble (1'b0),
      .i_d      (ex_mem_d),
      .o_q      (ex_mem_q)
   );

   memory_access u_memory (
      .i_clock  (i_clock),
      .i_ex_mem (ex_mem_q),
      .o_mem_wb (mem_wb_d)
   );

   stage_reg #(.T(mips_pkg::mem_wb_t)) u_mem_wb_reg (
      .i_clock  (i_clock),
      .reset    (reset),
      .i_hold   (1'b0),
      .i_bubble (1'b0),
      .i_d      (mem_wb_d),
      .o_q      (mem_wb_q)
   );

   // Sticky until reset
   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_halt <= 1'b0;
      end else if (mem_wb_q.valid && mem_wb_q.halt) begin
         o_halt <= 1'b1;
      end
   end

endmodule

/* hdl/mips_pkg.sv */
`include "mips_defs.svh"

package mips_pkg;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_t;

   // Source of an execute operand
   typedef enum logic [1:0] {
      FWD_RF  = 2'd0,
      FWD_MEM = 2'd1,
      FWD_WB  = 2'd2
   } fwd_sel_t;

   // Decode to execute
   typedef struct packed {
      logic                   valid;
      logic [`MIPS_RADDR-1:0] rs;
      logic [`MIPS_RADDR-1:0] rt;
      logic [`MIPS_XLEN-1:0]  rs_val;
      logic [`MIPS_XLEN-1:0]  rt_val;
      logic [`MIPS_XLEN-1:0]  imm;
      logic                   imm_sel;
      logic                   load;
      logic                   store;
      logic                   reg_write;
      logic                   halt;
      logic [`MIPS_RADDR-1:0] rd;
      alu_op_t                alu_op;
   } id_ex_t;

   // Execute to memory
   // The ALU result doubles as the data address
   typedef struct packed {
      logic                   valid;
      logic [`MIPS_XLEN-1:0]  alu_result;
      logic [`MIPS_XLEN-1:0]  store_data;
      logic                   load;
      logic                   store;
      logic                   reg_write;
      logic                   halt;
      logic [`MIPS_RADDR-1:0] rd;
   } ex_mem_t;

   // Memory to writeback
   typedef struct packed {
      logic                   valid;
      logic [`MIPS_XLEN-1:0]  wb_data;
      logic                   reg_write;
      logic                   halt;
      logic [`MIPS_RADDR-1:0] rd;
   } mem_wb_t;

endpackage

/* hdl/stage_reg.sv */
module stage_reg #(
   parameter type T = logic
) (
   input  logic i_clock,
   input  logic reset,
   input  logic i_hold,
   input  logic i_bubble,
   input  T     i_d,
   output T     o_q
);

   // Bubble wins over hold so a stalled stage never repeats an instruction
   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_q <= '0;
      end else if (i_bubble) begin
         o_q <= '0;
      end else if (!i_hold) begin
         o_q <= i_d;
      end
   end

endmodule

/* vlog.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/stage_reg.sv
hdl/instr_fetch.sv
hdl/instr_decode.sv
hdl/hazard_forward.sv
hdl/execute.sv
hdl/memory_access.sv
hdl/mips_pipeline.sv
bench/mips_pipeline_assert.sv
bench/mips_pipeline_tb.sv
